/* cpu_vectors.txt */
# P <instruction word hex>, in program order from index 0
# E <register hex> <value hex> in writeback order; H <index of the halt wait hex>
# alu and immediate forms
P 00200C90
P 025FDA90
P 02460001
P 02480004
P 026A0006
# store, load, move
P 22800101
P 22C00100
P 8AE00000
# branches, each condition taken and not taken
P 4000000B
P 01000030
P 42000009
P 01000230
P 44000009
P 01200030
P 4400000A
P 01200450
P 4200000A
P 01400030
P 4200000B
# halt wait, branch always, then terminate
P A0000000
P 40000008
P 01400030
P 13400670
P E0000000
P 01600030
H 13
E 1 00000064
E 2 FFFFFF38
E 3 0000012C
E 4 FFFFFF5C
E 5 00064000
E 6 FFFFFF5C
E 7 00064000
E 8 00000011
E 9 00000022
E A 00000055

/* list.f */
cpu_pkg.sv
cpu_sequencer.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
cpu_top.sv
cpu_asserts.sv
tb_cpu.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_cpu
FILELIST  = list.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* tb_cpu.sv */
`timescale 1ns/100ps

module tb_cpu;

    localparam int clk_half = 4;

    logic                            clk;
    logic                            rst;
    logic                            halt_button;
    logic                            imem_we;
    logic [cpu_pkg::mem_addr_w-1:0]  imem_addr;
    logic [cpu_pkg::data_w-1:0]      imem_wdata;
    logic                            wb_valid;
    logic [cpu_pkg::reg_addr_w-1:0]  wb_addr;
    logic [cpu_pkg::data_w-1:0]      wb_data;
    logic [cpu_pkg::mem_addr_w-1:0]  pc;
    logic                            halted;

    // contents of the vectors file
    logic [31:0]                     prog_words [$];
    logic [31:0]                     exp_addr [$];
    logic [31:0]                     exp_data [$];
    logic [cpu_pkg::mem_addr_w-1:0]  h_index;

    integer                          seed;
    int                              hold_len;
    int                              watchdog_cycles;
    int                              wb_count;
    logic                            started;

    cpu_top dut0 (
        .clk(clk), .rst(rst), .halt_button(halt_button), .imem_we(imem_we),
        .imem_addr(imem_addr), .imem_wdata(imem_wdata), .wb_valid(wb_valid),
        .wb_addr(wb_addr), .wb_data(wb_data), .pc(pc), .halted(halted)
    );

    always #(clk_half) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic abort_run(input string why);
        $display("error: %s", why);
        $display("TEST FAILED");
        $fatal(1, "%s", why);
    endtask

    // P word, E reg value, H index; # starts a comment line
    task automatic read_vectors();
        int            fd;
        int            code;
        logic [7:0]    tag;
        logic [31:0]   word;
        logic [31:0]   value;
        logic [1023:0] skip_line;
        bit            done;
        fd = $fopen("cpu_vectors.txt", "r");
        if (fd == 0)
        begin
            abort_run("cannot open cpu_vectors.txt");
        end
        else
        begin
            done = 1'b0;
            while (!done)
            begin
                code = $fscanf(fd, " %c", tag);
                if (code != 1)
                begin
                    done = 1'b1;
                end
                else if (tag == "#")
                begin
                    code = $fgets(skip_line, fd);
                end
                else if (tag == "P")
                begin
                    code = $fscanf(fd, " %h", word);
                    prog_words.push_back(word);
                end
                else if (tag == "E")
                begin
                    code = $fscanf(fd, " %h %h", word, value);
                    exp_addr.push_back(word);
                    exp_data.push_back(value);
                end
                else if (tag == "H")
                begin
                    code = $fscanf(fd, " %h", word);
                    h_index = word[cpu_pkg::mem_addr_w-1:0];
                end
                else
                begin
                    abort_run("unknown line tag in cpu_vectors.txt");
                end
            end
            $fclose(fd);
        end
    endtask

    // every writeback must match the next E line
    always @(negedge clk)
    begin
        if (!rst && wb_valid)
        begin
            if (halt_button)
            begin
                abort_run("writeback while halt_button is high");
            end
            else if (wb_count >= exp_addr.size())
            begin
                abort_run("writeback past the end of the expected trace");
            end
            else
            begin
                check_value($sformatf("writeback %0d reg", wb_count),
                            exp_addr[wb_count], 32'(wb_addr));
                check_value($sformatf("writeback %0d data", wb_count),
                            exp_data[wb_count], wb_data);
                wb_count++;
            end
        end
    end

    // press the button once the wait instruction is being fetched
    initial
    begin
        int release_cycles;
        wait (started);
        while (pc != h_index)
        begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        halt_button = 1'b1;
        repeat (hold_len) @(posedge clk);
        #1;
        halt_button = 1'b0;
        // still in decode here, then execute, memory and the pc update edge
        release_cycles = 0;
        while (pc == h_index)
        begin
            @(posedge clk);
            #1;
            release_cycles++;
        end
        check_value("cycles from release to pc update", 32'd3, 32'(release_cycles));
        // wait instruction itself is a no-op on the pc
        check_value("pc after halt wait", 32'(h_index) + 32'd1, 32'(pc));
    end

    initial
    begin
        wait (started);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: halted did not rise within %0d cycles", watchdog_cycles);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        int          rnd;
        logic [31:0] stop_word;
        clk         = 1'b0;
        rst         = 1'b1;
        halt_button = 1'b0;
        imem_we     = 1'b0;
        imem_addr   = '0;
        imem_wdata  = '0;
        h_index     = '0;
        started     = 1'b0;
        wb_count    = 0;
        seed        = 5;
        read_vectors();
        rnd             = $random(seed);
        hold_len        = 3 + ((rnd & 32'h7fff_ffff) % 10);
        watchdog_cycles = 5 * prog_words.size() + hold_len + 50;
        // program goes in while the core is held in reset
        for (int i = 0; i < prog_words.size(); i++)
        begin
            @(posedge clk);
            #1;
            imem_we    = 1'b1;
            imem_addr  = 8'(i);
            imem_wdata = prog_words[i];
        end
        @(posedge clk);
        #1;
        imem_we = 1'b0;
        // 4 more reset cycles after the load
        repeat (4) @(posedge clk);
        #1;
        rst     = 1'b0;
        started = 1'b1;
        while (!halted) @(negedge clk);
        // idle a little, nothing may write back now
        repeat (6) @(negedge clk);
        check_value("writeback count", 32'(exp_addr.size()), 32'(wb_count));
        check_value("halted held", 32'd1, 32'(halted));
        // terminate never reaches memory, so pc stays on it
        stop_word = prog_words[pc];
        check_value("opcode at halted pc", 32'(cpu_pkg::op_term), 32'(stop_word[31:29]));
        if (dut0.asserts0.fail_count == 0)
        begin
            $display("TEST PASSED");
            $finish;
        end
        else
        begin
            $display("error: %0d bound assertion failures", dut0.asserts0.fail_count);
            $display("TEST FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

/* cpu_asserts.sv */
`timescale 1ns/100ps

module cpu_asserts (
    input logic clk,
    input logic rst,
    input logic wb_valid,
    input logic halted
);

    // failing checks, counted
    int fail_count = 0;

    // one writeback per instruction, never back to back
    a_wb_single: assert property (@(posedge clk) disable iff (rst) wb_valid |=> !wb_valid)
    else
    begin
        fail_count++;
        $error("wb_valid high on two consecutive cycles");
    end

    // terminate step is absorbing, only rst leaves
    a_halt_sticky: assert property (@(posedge clk) (halted && !rst) |=> halted)
    else
    begin
        fail_count++;
        $error("halted fell without rst");
    end

    a_quiet_halt: assert property (@(posedge clk) disable iff (rst) halted |-> !wb_valid)
    else
    begin
        fail_count++;
        $error("wb_valid high while halted");
    end

endmodule

bind cpu_top cpu_asserts asserts0 (
    .clk(clk),
    .rst(rst),
    .wb_valid(wb_valid),
    .halted(halted)
);

/* cpu_top.sv */
`timescale 1ns/100ps

module cpu_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            halt_button,
    input  logic                            imem_we,
    input  logic [cpu_pkg::mem_addr_w-1:0]  imem_addr,
    input  logic [cpu_pkg::data_w-1:0]      imem_wdata,
    output logic                            wb_valid,
    output logic [cpu_pkg::reg_addr_w-1:0]  wb_addr,
    output logic [cpu_pkg::data_w-1:0]      wb_data,
    output logic [cpu_pkg::mem_addr_w-1:0]  pc,
    output logic                            halted
);

    cpu_pkg::step_t                 step;
    cpu_pkg::instr_t                ir;
    logic                           hold_req;
    logic                           term_req;
    // decode to execute and memory
    logic [cpu_pkg::data_w-1:0]     op_a;
    logic [cpu_pkg::data_w-1:0]     op_b;
    logic [cpu_pkg::data_w-1:0]     imm;
    logic [cpu_pkg::data_w-1:0]     pc_d;
    logic [2:0]                     alu_code;
    logic                           use_imm;
    logic                           use_pc;
    logic [1:0]                     cond;
    logic [2:0]                     opcode;
    logic [cpu_pkg::reg_addr_w-1:0] rt_d;
    logic                           ldst_store;
    // execute to memory
    logic [cpu_pkg::data_w-1:0]     alu_out;
    logic                           take_branch;
    logic [cpu_pkg::data_w-1:0]     store_data;
    // memory back to fetch
    logic [cpu_pkg::mem_addr_w-1:0] next_pc;
    logic                           pc_load;

    cpu_sequencer seq0 (
        .clk(clk), .rst(rst), .hold_req(hold_req), .term_req(term_req),
        .step(step), .halted(halted)
    );

    fetch_stage fetch0 (
        .clk(clk), .rst(rst), .step(step), .imem_we(imem_we), .imem_addr(imem_addr),
        .imem_wdata(imem_wdata), .next_pc(next_pc), .pc_load(pc_load), .ir(ir), .pc(pc)
    );

    decode_stage decode0 (
        .clk(clk), .rst(rst), .step(step), .ir(ir), .pc(pc), .halt_button(halt_button),
        .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data),
        .op_a(op_a), .op_b(op_b), .imm(imm), .pc_d(pc_d), .alu_code(alu_code),
        .use_imm(use_imm), .use_pc(use_pc), .cond(cond), .opcode(opcode), .rt_d(rt_d),
        .ldst_store(ldst_store), .hold_req(hold_req), .term_req(term_req)
    );

    execute_stage execute0 (
        .clk(clk), .rst(rst), .step(step), .op_a(op_a), .op_b(op_b), .imm(imm),
        .pc_d(pc_d), .alu_code(alu_code), .use_imm(use_imm), .use_pc(use_pc),
        .cond(cond), .opcode(opcode), .alu_out(alu_out), .take_branch(take_branch),
        .store_data(store_data)
    );

    memory_stage memory0 (
        .clk(clk), .rst(rst), .step(step), .opcode(opcode), .rt_d(rt_d),
        .ldst_store(ldst_store), .alu_out(alu_out), .take_branch(take_branch),
        .store_data(store_data), .pc(pc), .next_pc(next_pc), .pc_load(pc_load),
        .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data)
    );

endmodule

/* memory_stage.sv */
`timescale 1ns/100ps

module memory_stage (
    input  logic                            clk,
    input  logic                            rst,
    input  cpu_pkg::step_t                  step,
    input  logic [2:0]                      opcode,
    input  logic [cpu_pkg::reg_addr_w-1:0]  rt_d,
    input  logic                            ldst_store,
    input  logic [cpu_pkg::data_w-1:0]      alu_out,
    input  logic                            take_branch,
    input  logic [cpu_pkg::data_w-1:0]      store_data,
    input  logic [cpu_pkg::mem_addr_w-1:0]  pc,
    output logic [cpu_pkg::mem_addr_w-1:0]  next_pc,
    output logic                            pc_load,
    output logic                            wb_valid,
    output logic [cpu_pkg::reg_addr_w-1:0]  wb_addr,
    output logic [cpu_pkg::data_w-1:0]      wb_data
);

    logic [cpu_pkg::data_w-1:0]     dmem [cpu_pkg::dmem_depth];
    logic [cpu_pkg::data_w-1:0]     lmd;
    logic [cpu_pkg::mem_addr_w-1:0] daddr;
    logic [cpu_pkg::mem_addr_w-1:0] pc_inc;
    logic                           is_load;
    logic                           wb_pending;
    logic                           wb_from_mem;
    logic                           in_memory;

    assign in_memory = (step == cpu_pkg::st_memory);
    assign daddr     = alu_out[cpu_pkg::mem_addr_w-1:0];
    assign is_load   = (opcode == cpu_pkg::op_ldst) && !ldst_store;

    // every instruction that reaches memory moves the pc
    // reserved opcodes fall through as no-ops
    assign pc_inc  = pc + 1'b1;
    assign next_pc = take_branch ? alu_out[cpu_pkg::mem_addr_w-1:0] : pc_inc;
    assign pc_load = in_memory;

    always_ff @(posedge clk)
    begin
        if (in_memory)
        begin
            if ((opcode == cpu_pkg::op_ldst) && ldst_store)
            begin
                dmem[daddr] <= store_data;
            end
            lmd <= dmem[daddr];
        end
    end

    // remember what writeback has to do
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wb_pending  <= 1'b0;
            wb_from_mem <= 1'b0;
        end
        else if (in_memory)
        begin
            wb_pending  <= (opcode == cpu_pkg::op_alu) || (opcode == cpu_pkg::op_move) || is_load;
            wb_from_mem <= is_load;
        end
    end

    // single-cycle strobe in writeback
    assign wb_valid = (step == cpu_pkg::st_writeback) && wb_pending;
    assign wb_addr  = rt_d;
    assign wb_data  = wb_from_mem ? lmd : alu_out;

endmodule

/* execute_stage.sv */
`timescale 1ns/100ps

module execute_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  cpu_pkg::step_t              step,
    input  logic [cpu_pkg::data_w-1:0]  op_a,
    input  logic [cpu_pkg::data_w-1:0]  op_b,
    input  logic [cpu_pkg::data_w-1:0]  imm,
    input  logic [cpu_pkg::data_w-1:0]  pc_d,
    input  logic [2:0]                  alu_code,
    input  logic                        use_imm,
    input  logic                        use_pc,
    input  logic [1:0]                  cond,
    input  logic [2:0]                  opcode,
    output logic [cpu_pkg::data_w-1:0]  alu_out,
    output logic                        take_branch,
    output logic [cpu_pkg::data_w-1:0]  store_data
);

    logic [cpu_pkg::data_w-1:0] opnd1;
    logic [cpu_pkg::data_w-1:0] opnd2;
    logic [cpu_pkg::data_w-1:0] result;
    logic [2:0]                 code;
    logic                       cond_ok;

    // branch target is pc plus offset
    assign opnd1 = use_pc ? pc_d : op_a;
    assign opnd2 = use_imm ? imm : op_b;

    // address and target math is always an add
    assign code = ((opcode == cpu_pkg::op_ldst) || (opcode == cpu_pkg::op_branch))
                  ? cpu_pkg::alu_add : alu_code;

    always_comb
    begin
        case (code)
            cpu_pkg::alu_add: result = opnd1 + opnd2;
            cpu_pkg::alu_sub: result = opnd1 - opnd2;
            cpu_pkg::alu_and: result = opnd1 & opnd2;
            cpu_pkg::alu_or:  result = opnd1 | opnd2;
            cpu_pkg::alu_xor: result = opnd1 ^ opnd2;
            // shift amount from the low five bits
            cpu_pkg::alu_srl: result = opnd1 >> opnd2[4:0];
            cpu_pkg::alu_sll: result = opnd1 << opnd2[4:0];
            cpu_pkg::alu_sra: result = $signed(opnd1) >>> opnd2[4:0];
            default:          result = opnd1;
        endcase
    end

    // condition on rs, never on the target
    always_comb
    begin
        case (cond)
            cpu_pkg::cond_always: cond_ok = 1'b1;
            cpu_pkg::cond_neg:    cond_ok = op_a[cpu_pkg::data_w-1];
            cpu_pkg::cond_nonneg: cond_ok = !op_a[cpu_pkg::data_w-1];
            default:              cond_ok = (op_a == '0);
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            take_branch <= 1'b0;
        end
        else if (step == cpu_pkg::st_execute)
        begin
            take_branch <= (opcode == cpu_pkg::op_branch) && cond_ok;
        end
    end

    always_ff @(posedge clk)
    begin
        if (step == cpu_pkg::st_execute)
        begin
            // move passes rs straight through
            alu_out    <= (opcode == cpu_pkg::op_move) ? op_a : result;
            store_data <= op_b;
        end
    end

endmodule

/* decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
    input  logic                            clk,
    input  logic                            rst,
    input  cpu_pkg::step_t                  step,
    input  cpu_pkg::instr_t                 ir,
    input  logic [cpu_pkg::mem_addr_w-1:0]  pc,
    input  logic                            halt_button,
    input  logic                            wb_valid,
    input  logic [cpu_pkg::reg_addr_w-1:0]  wb_addr,
    input  logic [cpu_pkg::data_w-1:0]      wb_data,
    output logic [cpu_pkg::data_w-1:0]      op_a,
    output logic [cpu_pkg::data_w-1:0]      op_b,
    output logic [cpu_pkg::data_w-1:0]      imm,
    output logic [cpu_pkg::data_w-1:0]      pc_d,
    output logic [2:0]                      alu_code,
    output logic                            use_imm,
    output logic                            use_pc,
    output logic [1:0]                      cond,
    output logic [2:0]                      opcode,
    output logic [cpu_pkg::reg_addr_w-1:0]  rt_d,
    output logic                            ldst_store,
    output logic                            hold_req,
    output logic                            term_req
);

    logic [cpu_pkg::data_w-1:0]     regs [2**cpu_pkg::reg_addr_w];
    cpu_pkg::fmt_r_t                fr;
    cpu_pkg::fmt_b_t                fb;
    logic [cpu_pkg::data_w-1:0]     imm_ext;
    logic [cpu_pkg::reg_addr_w-1:0] wr_target;
    logic                           imm_sel;
    logic                           in_decode;

    // same word seen two ways
    assign fr = ir.fmt_r;
    assign fb = ir.fmt_b;

    assign in_decode = (step == cpu_pkg::st_decode);

    always_comb
    begin
        imm_ext   = {{16{fr.imm[15]}}, fr.imm};
        wr_target = fr.rt;
        imm_sel   = 1'b1;
        case (fr.opcode)
            cpu_pkg::op_alu:
            begin
                // funct[4] picks immediate form
                imm_sel = fr.funct[4];
                // register form writes rd, top of imm
                if (!fr.funct[4])
                begin
                    wr_target = fr.imm[15:12];
                end
            end
            cpu_pkg::op_branch:
            begin
                imm_ext = {{9{fb.imm[22]}}, fb.imm};
            end
            default:
            begin
                imm_sel = 1'b1;
            end
        endcase
    end

    // wait only on the bit-28-clear form
    assign hold_req = in_decode && (fr.opcode == cpu_pkg::op_pctl) && !ir[28] && halt_button;
    assign term_req = in_decode && (fr.opcode == cpu_pkg::op_term);

    // register file, cleared on reset
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 2**cpu_pkg::reg_addr_w; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb_valid)
        begin
            regs[wb_addr] <= wb_data;
        end
    end

    // control fields
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            opcode     <= cpu_pkg::op_pctl;
            use_imm    <= 1'b0;
            use_pc     <= 1'b0;
            ldst_store <= 1'b0;
        end
        else if (in_decode)
        begin
            opcode     <= fr.opcode;
            use_imm    <= imm_sel;
            use_pc     <= (fr.opcode == cpu_pkg::op_branch);
            ldst_store <= (fr.opcode == cpu_pkg::op_ldst) && fr.funct[0];
        end
    end

    // operands and payload
    always_ff @(posedge clk)
    begin
        if (in_decode)
        begin
            op_a     <= regs[fr.rs];
            op_b     <= regs[fr.rt];
            imm      <= imm_ext;
            pc_d     <= {{(cpu_pkg::data_w - cpu_pkg::mem_addr_w){1'b0}}, pc};
            alu_code <= fr.funct[2:0];
            cond     <= fb.cond;
            rt_d     <= wr_target;
        end
    end

endmodule

/* fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage (
    input  logic                            clk,
    input  logic                            rst,
    input  cpu_pkg::step_t                  step,
    input  logic                            imem_we,
    input  logic [cpu_pkg::mem_addr_w-1:0]  imem_addr,
    input  logic [cpu_pkg::data_w-1:0]      imem_wdata,
    input  logic [cpu_pkg::mem_addr_w-1:0]  next_pc,
    input  logic                            pc_load,
    output cpu_pkg::instr_t                 ir,
    output logic [cpu_pkg::mem_addr_w-1:0]  pc
);

    // program store, word addressed
    logic [cpu_pkg::data_w-1:0] imem [cpu_pkg::imem_depth];

    // loader writes only while the core sits in reset
    always_ff @(posedge clk)
    begin
        if (rst && imem_we)
        begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    // pc steps by one word, memory stage picks the value
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc <= '0;
        end
        else if (pc_load)
        begin
            pc <= next_pc;
        end
    end

    // latch the instruction at fetch
    always_ff @(posedge clk)
    begin
        if (step == cpu_pkg::st_fetch)
        begin
            ir <= imem[pc];
        end
    end

endmodule

/* cpu_sequencer.sv */
`timescale 1ns/100ps

module cpu_sequencer (
    input  logic                clk,
    input  logic                rst,
    input  logic                hold_req,
    input  logic                term_req,
    output cpu_pkg::step_t      step,
    output logic                halted
);

    cpu_pkg::step_t step_nxt;

    always_comb
    begin
        step_nxt = step;
        case (step)
            cpu_pkg::st_fetch:
            begin
                step_nxt = cpu_pkg::st_decode;
            end
            cpu_pkg::st_decode:
            begin
                // terminate wins over a wait
                if (term_req)
                begin
                    step_nxt = cpu_pkg::st_term;
                end
                else if (!hold_req)
                begin
                    step_nxt = cpu_pkg::st_execute;
                end
            end
            cpu_pkg::st_execute:
            begin
                step_nxt = cpu_pkg::st_memory;
            end
            cpu_pkg::st_memory:
            begin
                step_nxt = cpu_pkg::st_writeback;
            end
            cpu_pkg::st_writeback:
            begin
                step_nxt = cpu_pkg::st_fetch;
            end
            cpu_pkg::st_term:
            begin
                // absorbing, only rst leaves
                step_nxt = cpu_pkg::st_term;
            end
            default:
            begin
                step_nxt = cpu_pkg::st_fetch;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            step <= cpu_pkg::st_fetch;
        end
        else
        begin
            step <= step_nxt;
        end
    end

    assign halted = (step == cpu_pkg::st_term);

endmodule

/* cpu_pkg.sv */
package cpu_pkg;

    // word widths
    localparam int data_w     = 32;
    localparam int reg_addr_w = 4;

    // memory sizes, in words
    localparam int imem_depth = 256;
    localparam int dmem_depth = 256;
    localparam int mem_addr_w = 8;

    // major opcodes in bits 31:29
    localparam logic [2:0] op_alu    = 3'b000;
    localparam logic [2:0] op_ldst   = 3'b001;
    localparam logic [2:0] op_branch = 3'b010;
    localparam logic [2:0] op_move   = 3'b100;
    localparam logic [2:0] op_pctl   = 3'b101;
    localparam logic [2:0] op_term   = 3'b111;

    // alu function codes, low 3 bits of funct
    localparam logic [2:0] alu_add = 3'd0;
    localparam logic [2:0] alu_sub = 3'd1;
    localparam logic [2:0] alu_and = 3'd2;
    localparam logic [2:0] alu_or  = 3'd3;
    localparam logic [2:0] alu_xor = 3'd4;
    localparam logic [2:0] alu_srl = 3'd5;
    localparam logic [2:0] alu_sll = 3'd6;
    localparam logic [2:0] alu_sra = 3'd7;

    // branch conditions, tested on rs
    localparam logic [1:0] cond_always = 2'b00;
    localparam logic [1:0] cond_neg    = 2'b01;
    localparam logic [1:0] cond_nonneg = 2'b10;
    localparam logic [1:0] cond_zero   = 2'b11;

    // one instruction walks these in order
    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback,
        st_term
    } step_t;

    // alu, load/store, move and program control
    // rd sits in the top four bits of imm
    typedef struct packed {
        logic [2:0]  opcode;
        logic [3:0]  rs;
        logic [3:0]  rt;
        logic [15:0] imm;
        logic [4:0]  funct;
    } fmt_r_t;

    // branches with the long offset
    typedef struct packed {
        logic [2:0]  opcode;
        logic [3:0]  rs;
        logic [22:0] imm;
        logic [1:0]  cond;
    } fmt_b_t;

    typedef union packed {
        fmt_r_t fmt_r;
        fmt_b_t fmt_b;
    } instr_t;

endpackage
